//--- Makefile
# Verilator build and run for the load/store debug-trigger interface

VERILATOR ?= verilator
TOP       ?= tb_lsu_dtif
RTL_TOP   ?= lsu_dtif
FILELIST  ?= files.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert
RTL_FILES ?= dtif_pkg.sv dtif_fsm.sv dtif_req_gen.sv lsu_dtif.sv

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: build
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@grep -q "TEST PASSED" $(LOG)

lint:
	$(VERILATOR) --lint-only -Wall --top-module $(RTL_TOP) $(RTL_FILES)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- dtif_fsm.sv
// debug-trigger check FSM with request strobes, stall and completion control
`timescale 1ns/1ps

module dtif_fsm (
  input  logic dt_fsm_clk,
  input  logic cpurst_b,
  input  logic req,
  input  logic addr_ready,
  input  logic st_type,
  input  logic split_last,
  input  logic data_chk_mask,
  input  logic pipe_down,
  input  logic any_data_vld,
  input  logic addr_trig_en,
  input  logic data_trig_en,
  input  logic halt_info_vld,
  input  logic halt_cancel,
  input  logic flush,
  output logic fsm_idle,
  output logic stall,
  output logic cmplt_ready,
  output logic pipedown_mask,
  output logic halt_info_up,
  output logic addr_up,
  output logic data_up,
  output logic addr_req,
  output logic data_req,
  output logic data_chk_en
);

  import dtif_pkg::*;

  dt_state_t cur_state;
  dt_state_t next_state;
  logic      wait_state;
  logic      addr_chk_en;
  logic      addr_start;
  logic      data_start;
  logic      cancel;
  logic      in_chk;

  // ==============================
  // start and cancel decode
  // ==============================
  // data is checked once per split inst, vector data never
  assign data_chk_en = data_trig_en && !data_chk_mask;
  assign addr_chk_en = addr_trig_en;

  assign addr_start = req && addr_ready && addr_chk_en;
  assign data_start = req && data_chk_en && !addr_chk_en;

  assign cancel = halt_info_vld && halt_cancel;

  // ==============================
  // state register
  // ==============================
  always_ff @(posedge dt_fsm_clk or negedge cpurst_b)
  begin
    if (!cpurst_b)
      cur_state <= idle;
    else if (flush)
      cur_state <= idle;
    else
      cur_state <= next_state;
  end

  always_comb
  begin
    next_state = cur_state;
    case (cur_state)
      idle:
      begin
        if (addr_start)
          next_state = addr_chk;
        else if (data_start && st_type)
          next_state = wait_data;
        else if (data_start)
          next_state = wait_pipe;
      end
      addr_chk:
      begin
        if (halt_info_vld && split_last && !data_chk_en || cancel)
          next_state = wait_cmplt;
        else if (halt_info_vld && data_chk_en && st_type)
          next_state = wait_data;
        else if (halt_info_vld)
          next_state = wait_pipe;
      end
      data_chk:
      begin
        if (halt_info_vld && split_last || cancel)
          next_state = wait_cmplt;
        else if (halt_info_vld)
          next_state = wait_pipe;
      end
      wait_data:
      begin
        if (any_data_vld)
          next_state = data_chk;
      end
      wait_pipe:
      begin
        // load data is only ready once the pipe has drained
        if (pipe_down && !st_type && data_chk_en)
          next_state = wait_data;
        else if (pipe_down)
          next_state = idle;
      end
      wait_cmplt:
      begin
        if (pipe_down)
          next_state = idle;
      end
      default: next_state = idle;
    endcase
  end

  // ==============================
  // wait flag
  // ==============================
  // first cycle of a check state is the request, then hold until the answer
  assign in_chk = (cur_state == addr_chk) || (cur_state == data_chk);

  always_ff @(posedge dt_fsm_clk or negedge cpurst_b)
  begin
    if (!cpurst_b)
      wait_state <= 1'b0;
    else if (flush || in_chk && halt_info_vld)
      wait_state <= 1'b0;
    else if (in_chk)
      wait_state <= 1'b1;
  end

  assign addr_req = (cur_state == addr_chk) && !wait_state;
  assign data_req = (cur_state == data_chk) && !wait_state;

  // ==============================
  // outputs
  // ==============================
  assign fsm_idle = (cur_state == idle);

  assign stall = fsm_idle && req && (addr_chk_en || data_chk_en)
                 || in_chk
                 || (cur_state == wait_data);

  assign cmplt_ready = (cur_state == wait_cmplt);

  // load completion must wait for pipedown
  assign pipedown_mask = (cur_state == wait_cmplt) && data_chk_en && !st_type;

  assign halt_info_up = in_chk && halt_info_vld;

  // capture strobes toward the request generator
  assign addr_up = fsm_idle && addr_start;
  assign data_up = (cur_state == wait_data) && any_data_vld;

  // ==============================
  // assertions
  // ==============================
  a_req_onehot: assert property (
    @(posedge dt_fsm_clk) disable iff (!cpurst_b)
    !(addr_req && data_req)
  );

  a_state_legal: assert property (
    @(posedge dt_fsm_clk) disable iff (!cpurst_b)
    cur_state inside {idle, addr_chk, data_chk, wait_data, wait_pipe, wait_cmplt}
  );

endmodule

//--- dtif_pkg.sv
// debug-trigger interface shared widths, check states and load/store type codes
package dtif_pkg;

  // ==============================
  // widths
  // ==============================
  localparam int pa_width        = 40;
  localparam int data_width      = 64;
  localparam int bytes_vld_width = 16;
  localparam int size_width      = 3;

  // halt info from the trigger unit
  localparam int hinfo_width      = 22;
  localparam int hinfo_cancel_bit = 0;

  // ==============================
  // check state encoding
  // ==============================
  typedef enum logic [2:0] {
    idle       = 3'd0,
    addr_chk   = 3'd1,
    data_chk   = 3'd2,
    wait_data  = 3'd3,
    wait_pipe  = 3'd4,
    wait_cmplt = 3'd5
  } dt_state_t;

  // ==============================
  // load/store type codes
  // ==============================
  // bit 1 marks a load, bit 0 a store
  typedef logic [1:0] ldst_type_t;

  localparam ldst_type_t ldst_store = 2'b01;
  localparam ldst_type_t ldst_load  = 2'b10;
  // atomics check both sides on the address request
  localparam ldst_type_t ldst_amo   = 2'b11;

endpackage

//--- dtif_req_gen.sv
// trigger request generator with address and data snapshots, type and last-check
`timescale 1ns/1ps

module dtif_req_gen (
  input  logic                                    dt_fsm_clk,
  input  logic                                    cpurst_b,
  input  logic                                    addr_up,
  input  logic                                    data_up,
  input  logic                                    addr_req,
  input  logic                                    data_req,
  input  logic                                    data_chk_en,
  input  logic                                    addr_trig_en,
  input  logic                                    st_type,
  input  logic                                    amo_type,
  input  logic                                    split_last,
  input  logic [dtif_pkg::pa_width-1:0]           addr,
  input  logic [dtif_pkg::bytes_vld_width-1:0]    bytes_vld,
  input  logic [dtif_pkg::data_width-1:0]         ag_data,
  input  logic                                    ag_data_vld,
  input  logic [dtif_pkg::data_width-1:0]         da_data,
  input  logic                                    da_data_vld,
  input  logic [dtif_pkg::data_width-1:0]         vlsu_data,
  output logic [dtif_pkg::pa_width-1:0]           ldst_addr,
  output logic [dtif_pkg::bytes_vld_width-1:0]    ldst_bytes_vld,
  output logic [dtif_pkg::data_width-1:0]         ldst_data,
  output dtif_pkg::ldst_type_t                    ldst_type,
  output logic                                    last_check
);

  import dtif_pkg::*;

  logic [data_width-1:0] sel_data;
  logic                  addr_last;
  logic                  data_last;
  logic                  addr_last_ff;
  logic                  data_last_ff;
  logic                  load_data_ff;
  ldst_type_t            addr_type;
  ldst_type_t            data_type;

  // ==============================
  // data source select
  // ==============================
  // da first, then ag, vlsu as the fallback
  always_comb
  begin
    if (da_data_vld)
      sel_data = da_data;
    else if (ag_data_vld)
      sel_data = ag_data;
    else
      sel_data = vlsu_data;
  end

  // ==============================
  // snapshots
  // ==============================
  // address is the last check only when no data check follows
  assign addr_last = split_last && !data_chk_en;
  assign data_last = !addr_trig_en || !st_type || split_last;

  always_ff @(posedge dt_fsm_clk or negedge cpurst_b)
  begin
    if (!cpurst_b)
    begin
      ldst_addr      <= '0;
      ldst_bytes_vld <= '0;
      addr_last_ff   <= 1'b0;
    end
    else if (addr_up)
    begin
      ldst_addr      <= addr;
      ldst_bytes_vld <= bytes_vld;
      addr_last_ff   <= addr_last;
    end
  end

  always_ff @(posedge dt_fsm_clk or negedge cpurst_b)
  begin
    if (!cpurst_b)
    begin
      ldst_data    <= '0;
      load_data_ff <= 1'b0;
      data_last_ff <= 1'b0;
    end
    else if (data_up)
    begin
      ldst_data    <= sel_data;
      // da returns load data
      load_data_ff <= da_data_vld;
      data_last_ff <= data_last;
    end
  end

  // ==============================
  // type and last check
  // ==============================
  // amo checks both sides on the address request
  always_comb
  begin
    if (amo_type)
      addr_type = ldst_amo;
    else if (st_type)
      addr_type = ldst_store;
    else
      addr_type = ldst_load;
  end

  assign data_type = load_data_ff ? ldst_load : ldst_store;
  assign ldst_type = addr_req ? addr_type : data_type;

  assign last_check = addr_req && addr_last_ff || data_req && data_last_ff;

  // ==============================
  // assertions
  // ==============================
  a_last_in_req: assert property (
    @(posedge dt_fsm_clk) disable iff (!cpurst_b)
    last_check |-> (addr_req || data_req)
  );

endmodule

//--- files.f
dtif_pkg.sv
dtif_fsm.sv
dtif_req_gen.sv
lsu_dtif.sv
tb_clk_gen.sv
tb_lsu_dtif.sv

//--- lsu_dtif.sv
// load/store debug-trigger interface between address stage and trigger unit
`timescale 1ns/1ps

module lsu_dtif (
  input  logic                                  dt_fsm_clk,
  input  logic                                  cpurst_b,
  input  logic                                  ag_dtu_req,
  input  logic                                  ag_dtu_addr_ready,
  input  logic                                  ag_dtu_st_type,
  input  logic                                  ag_dtu_amo_type,
  input  logic                                  ag_dtu_split_last,
  input  logic                                  ag_dtu_data_chk_mask,
  input  logic                                  ag_dtu_pipe_down,
  input  logic [dtif_pkg::pa_width-1:0]         ag_dtu_addr,
  input  logic [dtif_pkg::bytes_vld_width-1:0]  ag_dtu_bytes_vld,
  input  logic [dtif_pkg::data_width-1:0]       ag_dtu_data,
  input  logic                                  ag_dtu_data_vld,
  input  logic [dtif_pkg::hinfo_width-1:0]      ag_dtu_halt_info,
  input  logic [dtif_pkg::size_width-1:0]       ag_dtu_mem_access_size,
  input  logic [dtif_pkg::data_width-1:0]       da_dtu_data,
  input  logic                                  da_dtu_data_vld,
  input  logic [dtif_pkg::data_width-1:0]       vlsu_dtu_data,
  input  logic                                  vlsu_dtu_data_vld,
  input  logic                                  dtu_lsu_addr_trig_en,
  input  logic                                  dtu_lsu_data_trig_en,
  input  logic [dtif_pkg::hinfo_width-1:0]      dtu_lsu_halt_info,
  input  logic                                  dtu_lsu_halt_info_vld,
  input  logic                                  rtu_yy_xx_flush,
  output logic                                  dtif_ag_stall,
  output logic                                  dtif_ag_cmplt_ready,
  output logic                                  dtif_ag_fsm_idle,
  output logic                                  dtif_ag_pipedown_mask,
  output logic                                  dtif_ag_halt_info_up,
  output logic [dtif_pkg::hinfo_width-1:0]      dtif_ag_halt_info,
  output logic                                  dtif_ag_trig_en,
  output logic                                  lsu_dtu_ldst_addr_vld,
  output logic [dtif_pkg::pa_width-1:0]         lsu_dtu_ldst_addr,
  output logic [dtif_pkg::bytes_vld_width-1:0]  lsu_dtu_ldst_bytes_vld,
  output logic                                  lsu_dtu_ldst_data_vld,
  output logic [dtif_pkg::data_width-1:0]       lsu_dtu_ldst_data,
  output dtif_pkg::ldst_type_t                  lsu_dtu_ldst_type,
  output logic                                  lsu_dtu_last_check,
  output logic [dtif_pkg::size_width-1:0]       lsu_dtu_mem_access_size,
  output logic [dtif_pkg::hinfo_width-1:0]      lsu_dtu_halt_info
);

  import dtif_pkg::*;

  logic addr_up;
  logic data_up;
  logic addr_req;
  logic data_req;
  logic data_chk_en;
  logic any_data_vld;

  assign any_data_vld = ag_dtu_data_vld || da_dtu_data_vld || vlsu_dtu_data_vld;

  // ==============================
  // check FSM
  // ==============================
  dtif_fsm u_fsm (
    .dt_fsm_clk    (dt_fsm_clk),
    .cpurst_b      (cpurst_b),
    .req           (ag_dtu_req),
    .addr_ready    (ag_dtu_addr_ready),
    .st_type       (ag_dtu_st_type),
    .split_last    (ag_dtu_split_last),
    .data_chk_mask (ag_dtu_data_chk_mask),
    .pipe_down     (ag_dtu_pipe_down),
    .any_data_vld  (any_data_vld),
    .addr_trig_en  (dtu_lsu_addr_trig_en),
    .data_trig_en  (dtu_lsu_data_trig_en),
    .halt_info_vld (dtu_lsu_halt_info_vld),
    .halt_cancel   (dtu_lsu_halt_info[hinfo_cancel_bit]),
    .flush         (rtu_yy_xx_flush),
    .fsm_idle      (dtif_ag_fsm_idle),
    .stall         (dtif_ag_stall),
    .cmplt_ready   (dtif_ag_cmplt_ready),
    .pipedown_mask (dtif_ag_pipedown_mask),
    .halt_info_up  (dtif_ag_halt_info_up),
    .addr_up       (addr_up),
    .data_up       (data_up),
    .addr_req      (addr_req),
    .data_req      (data_req),
    .data_chk_en   (data_chk_en)
  );

  // ==============================
  // request generator
  // ==============================
  dtif_req_gen u_req_gen (
    .dt_fsm_clk     (dt_fsm_clk),
    .cpurst_b       (cpurst_b),
    .addr_up        (addr_up),
    .data_up        (data_up),
    .addr_req       (addr_req),
    .data_req       (data_req),
    .data_chk_en    (data_chk_en),
    .addr_trig_en   (dtu_lsu_addr_trig_en),
    .st_type        (ag_dtu_st_type),
    .amo_type       (ag_dtu_amo_type),
    .split_last     (ag_dtu_split_last),
    .addr           (ag_dtu_addr),
    .bytes_vld      (ag_dtu_bytes_vld),
    .ag_data        (ag_dtu_data),
    .ag_data_vld    (ag_dtu_data_vld),
    .da_data        (da_dtu_data),
    .da_data_vld    (da_dtu_data_vld),
    .vlsu_data      (vlsu_dtu_data),
    .ldst_addr      (lsu_dtu_ldst_addr),
    .ldst_bytes_vld (lsu_dtu_ldst_bytes_vld),
    .ldst_data      (lsu_dtu_ldst_data),
    .ldst_type      (lsu_dtu_ldst_type),
    .last_check     (lsu_dtu_last_check)
  );

  assign lsu_dtu_ldst_addr_vld = addr_req;
  assign lsu_dtu_ldst_data_vld = data_req;

  // halt info and access size pass straight through
  assign dtif_ag_halt_info       = dtu_lsu_halt_info;
  assign lsu_dtu_halt_info       = ag_dtu_halt_info;
  assign lsu_dtu_mem_access_size = ag_dtu_mem_access_size;

  // keeps the address stage from completing early while any check is on
  assign dtif_ag_trig_en = dtu_lsu_addr_trig_en || data_chk_en;

endmodule

//--- tb_clk_gen.sv
// testbench clock source with power-on reset held low for the first cycles
`timescale 1ns/1ps

module tb_clk_gen (
  output logic dt_fsm_clk,
  output logic cpurst_b
);

  localparam int half_period  = 10;
  localparam int reset_cycles = 16;

  initial
  begin
    dt_fsm_clk = 1'b0;
    forever #half_period dt_fsm_clk = ~dt_fsm_clk;
  end

  initial
  begin
    cpurst_b = 1'b0;
    repeat (reset_cycles) @(posedge dt_fsm_clk);
    cpurst_b <= 1'b1;
  end

endmodule

//--- tb_lsu_dtif.sv
// testbench for the load/store debug-trigger interface
`timescale 1ns/1ps

module tb_lsu_dtif;

  import dtif_pkg::*;

  localparam int timeout_cycles = 200;
  localparam int addr_word_w    = pa_width + bytes_vld_width + 3;
  localparam int data_word_w    = data_width + 3;

  // wait targets
  localparam int see_addr_req = 0;
  localparam int see_data_req = 1;
  localparam int see_idle     = 2;
  localparam int see_reset    = 3;

  logic dt_fsm_clk;
  logic cpurst_b;

  logic ag_dtu_req, ag_dtu_addr_ready, ag_dtu_st_type, ag_dtu_amo_type;
  logic ag_dtu_split_last, ag_dtu_data_chk_mask, ag_dtu_pipe_down;
  logic ag_dtu_data_vld, da_dtu_data_vld, vlsu_dtu_data_vld;
  logic [pa_width-1:0]        ag_dtu_addr;
  logic [bytes_vld_width-1:0] ag_dtu_bytes_vld;
  logic [data_width-1:0]      ag_dtu_data, da_dtu_data, vlsu_dtu_data;
  logic [hinfo_width-1:0]     ag_dtu_halt_info, dtu_lsu_halt_info;
  logic [size_width-1:0]      ag_dtu_mem_access_size;
  logic dtu_lsu_addr_trig_en, dtu_lsu_data_trig_en, dtu_lsu_halt_info_vld;
  logic rtu_yy_xx_flush;

  logic dtif_ag_stall, dtif_ag_cmplt_ready, dtif_ag_fsm_idle, dtif_ag_pipedown_mask;
  logic dtif_ag_halt_info_up, dtif_ag_trig_en;
  logic [hinfo_width-1:0]     dtif_ag_halt_info, lsu_dtu_halt_info;
  logic lsu_dtu_ldst_addr_vld, lsu_dtu_ldst_data_vld, lsu_dtu_last_check;
  logic [pa_width-1:0]        lsu_dtu_ldst_addr;
  logic [bytes_vld_width-1:0] lsu_dtu_ldst_bytes_vld;
  logic [data_width-1:0]      lsu_dtu_ldst_data;
  ldst_type_t                 lsu_dtu_ldst_type;
  logic [size_width-1:0]      lsu_dtu_mem_access_size;

  // expected values and check triggers
  string test_name;
  int    test_errs, err_total, tests_run, tests_failed;
  logic [addr_word_w-1:0] exp_addr_word;
  logic [data_word_w-1:0] exp_data_word;
  logic [hinfo_width-1:0] exp_hinfo;
  logic [7:0] addr_pulses, data_pulses, exp_addr_pulses, exp_data_pulses;
  logic stall_exp, reset_chk, end_chk, cnt_clr;
  logic exp_trig_en;

  logic [addr_word_w-1:0] addr_word;
  logic [data_word_w-1:0] data_word;
  logic [6:0]             ctrl_word;

  tb_clk_gen u_clk_gen (
    .dt_fsm_clk (dt_fsm_clk),
    .cpurst_b   (cpurst_b)
  );

  lsu_dtif lsu_dtif_i (
    .dt_fsm_clk              (dt_fsm_clk),
    .cpurst_b                (cpurst_b),
    .ag_dtu_req              (ag_dtu_req),
    .ag_dtu_addr_ready       (ag_dtu_addr_ready),
    .ag_dtu_st_type          (ag_dtu_st_type),
    .ag_dtu_amo_type         (ag_dtu_amo_type),
    .ag_dtu_split_last       (ag_dtu_split_last),
    .ag_dtu_data_chk_mask    (ag_dtu_data_chk_mask),
    .ag_dtu_pipe_down        (ag_dtu_pipe_down),
    .ag_dtu_addr             (ag_dtu_addr),
    .ag_dtu_bytes_vld        (ag_dtu_bytes_vld),
    .ag_dtu_data             (ag_dtu_data),
    .ag_dtu_data_vld         (ag_dtu_data_vld),
    .ag_dtu_halt_info        (ag_dtu_halt_info),
    .ag_dtu_mem_access_size  (ag_dtu_mem_access_size),
    .da_dtu_data             (da_dtu_data),
    .da_dtu_data_vld         (da_dtu_data_vld),
    .vlsu_dtu_data           (vlsu_dtu_data),
    .vlsu_dtu_data_vld       (vlsu_dtu_data_vld),
    .dtu_lsu_addr_trig_en    (dtu_lsu_addr_trig_en),
    .dtu_lsu_data_trig_en    (dtu_lsu_data_trig_en),
    .dtu_lsu_halt_info       (dtu_lsu_halt_info),
    .dtu_lsu_halt_info_vld   (dtu_lsu_halt_info_vld),
    .rtu_yy_xx_flush         (rtu_yy_xx_flush),
    .dtif_ag_stall           (dtif_ag_stall),
    .dtif_ag_cmplt_ready     (dtif_ag_cmplt_ready),
    .dtif_ag_fsm_idle        (dtif_ag_fsm_idle),
    .dtif_ag_pipedown_mask   (dtif_ag_pipedown_mask),
    .dtif_ag_halt_info_up    (dtif_ag_halt_info_up),
    .dtif_ag_halt_info       (dtif_ag_halt_info),
    .dtif_ag_trig_en         (dtif_ag_trig_en),
    .lsu_dtu_ldst_addr_vld   (lsu_dtu_ldst_addr_vld),
    .lsu_dtu_ldst_addr       (lsu_dtu_ldst_addr),
    .lsu_dtu_ldst_bytes_vld  (lsu_dtu_ldst_bytes_vld),
    .lsu_dtu_ldst_data_vld   (lsu_dtu_ldst_data_vld),
    .lsu_dtu_ldst_data       (lsu_dtu_ldst_data),
    .lsu_dtu_ldst_type       (lsu_dtu_ldst_type),
    .lsu_dtu_last_check      (lsu_dtu_last_check),
    .lsu_dtu_mem_access_size (lsu_dtu_mem_access_size),
    .lsu_dtu_halt_info       (lsu_dtu_halt_info)
  );

  assign addr_word = {lsu_dtu_ldst_addr, lsu_dtu_ldst_bytes_vld, lsu_dtu_ldst_type,
                      lsu_dtu_last_check};
  assign data_word = {lsu_dtu_ldst_data, lsu_dtu_ldst_type, lsu_dtu_last_check};
  assign ctrl_word = {dtif_ag_fsm_idle, dtif_ag_stall, dtif_ag_cmplt_ready,
                      dtif_ag_pipedown_mask, lsu_dtu_ldst_addr_vld, lsu_dtu_ldst_data_vld,
                      lsu_dtu_last_check};

  // request pulses seen in the current test
  always @(posedge dt_fsm_clk)
  begin
    if (cnt_clr)
    begin
      addr_pulses <= 8'd0;
      data_pulses <= 8'd0;
    end
    else
    begin
      if (lsu_dtu_ldst_addr_vld)
        addr_pulses <= addr_pulses + 8'd1;
      if (lsu_dtu_ldst_data_vld)
        data_pulses <= data_pulses + 8'd1;
    end
  end

  task automatic report_value(input string what, input logic [79:0] expected,
                              input logic [79:0] actual);
    $display("** Error [%s] %s: expected %0h, actual %0h", test_name, what, expected, actual);
    test_errs++;
    err_total++;
  endtask

  task automatic report_plain(input string what);
    $display("[%s] %s", test_name, what);
    test_errs++;
    err_total++;
  endtask

  // ==============================
  // checks
  // ==============================
  a_reset_state: assert property (@(posedge dt_fsm_clk) disable iff (!cpurst_b)
    reset_chk |-> ctrl_word == 7'b1000000)
    else report_value("control outputs", 80'(7'b1000000), 80'($sampled(ctrl_word)));

  a_addr_req: assert property (@(posedge dt_fsm_clk) disable iff (!cpurst_b)
    lsu_dtu_ldst_addr_vld |-> addr_word == exp_addr_word)
    else report_value("address request", 80'($sampled(exp_addr_word)),
                      80'($sampled(addr_word)));

  a_data_req: assert property (@(posedge dt_fsm_clk) disable iff (!cpurst_b)
    lsu_dtu_ldst_data_vld |-> data_word == exp_data_word)
    else report_value("data request", 80'($sampled(exp_data_word)), 80'($sampled(data_word)));

  a_addr_pulse: assert property (@(posedge dt_fsm_clk) disable iff (!cpurst_b)
    lsu_dtu_ldst_addr_vld |=> !lsu_dtu_ldst_addr_vld)
    else report_plain("address request lasted more than one cycle");

  a_data_pulse: assert property (@(posedge dt_fsm_clk) disable iff (!cpurst_b)
    lsu_dtu_ldst_data_vld |=> !lsu_dtu_ldst_data_vld)
    else report_plain("data request lasted more than one cycle");

  a_stall: assert property (@(posedge dt_fsm_clk) disable iff (!cpurst_b)
    stall_exp |-> dtif_ag_stall)
    else report_plain("stall dropped while a check was still pending");

  a_halt_up: assert property (@(posedge dt_fsm_clk) disable iff (!cpurst_b)
    dtu_lsu_halt_info_vld |-> dtif_ag_halt_info_up && dtif_ag_halt_info == exp_hinfo)
    else report_value("halt info", 80'({1'b1, $sampled(exp_hinfo)}),
                      80'({$sampled(dtif_ag_halt_info_up), $sampled(dtif_ag_halt_info)}));

  a_cancel: assert property (@(posedge dt_fsm_clk) disable iff (!cpurst_b)
    dtu_lsu_halt_info_vld && dtu_lsu_halt_info[hinfo_cancel_bit] |=> dtif_ag_cmplt_ready)
    else report_plain("completion ready did not follow the cancel");

  a_cmplt_hold: assert property (@(posedge dt_fsm_clk) disable iff (!cpurst_b)
    dtif_ag_cmplt_ready && !ag_dtu_pipe_down && !rtu_yy_xx_flush |=> dtif_ag_cmplt_ready)
    else report_plain("completion ready dropped before the pipe drained");

  a_cmplt_idle: assert property (@(posedge dt_fsm_clk) disable iff (!cpurst_b)
    dtif_ag_cmplt_ready && ag_dtu_pipe_down |=> dtif_ag_fsm_idle)
    else report_plain("no return to idle after pipe down");

  a_flush: assert property (@(posedge dt_fsm_clk) disable iff (!cpurst_b)
    rtu_yy_xx_flush |=> dtif_ag_fsm_idle && !dtif_ag_stall)
    else report_plain("flush did not return to idle with stall low");

  a_trig_en: assert property (@(posedge dt_fsm_clk) disable iff (!cpurst_b)
    dtif_ag_trig_en == exp_trig_en)
    else report_value("trigger enable", 80'($sampled(exp_trig_en)),
                      80'($sampled(dtif_ag_trig_en)));

  // halt info and access size toward the trigger unit follow the address stage
  a_pass_through: assert property (@(posedge dt_fsm_clk) disable iff (!cpurst_b)
    {lsu_dtu_halt_info, lsu_dtu_mem_access_size} ==
    {ag_dtu_halt_info, ag_dtu_mem_access_size})
    else report_value("halt info and access size",
                      80'($sampled({ag_dtu_halt_info, ag_dtu_mem_access_size})),
                      80'($sampled({lsu_dtu_halt_info, lsu_dtu_mem_access_size})));

  a_pulse_count: assert property (@(posedge dt_fsm_clk) disable iff (!cpurst_b)
    end_chk |-> {addr_pulses, data_pulses} == {exp_addr_pulses, exp_data_pulses})
    else report_value("request pulse count", 80'($sampled({exp_addr_pulses, exp_data_pulses})),
                      80'($sampled({addr_pulses, data_pulses})));

  // ==============================
  // stimulus helpers
  // ==============================
  function automatic logic watched(input int which);
    case (which)
      see_addr_req: return lsu_dtu_ldst_addr_vld;
      see_data_req: return lsu_dtu_ldst_data_vld;
      see_idle:     return dtif_ag_fsm_idle;
      default:      return cpurst_b;
    endcase
  endfunction

  // polled on the falling edge where outputs are settled
  task automatic wait_for(input int which, input string what);
    int n;
    n = 0;
    @(negedge dt_fsm_clk);
    while (!watched(which) && n < timeout_cycles)
    begin
      @(negedge dt_fsm_clk);
      n++;
    end
    if (!watched(which))
    begin
      $display("[%s] timed out after %0d cycles waiting for %s", test_name, n, what);
      $display("TEST FAILED");
      $finish;
    end
  endtask

  task automatic start_test(input string name);
    test_name = name;
    test_errs = 0;
    @(posedge dt_fsm_clk);
    cnt_clr <= 1'b1;
    @(posedge dt_fsm_clk);
    cnt_clr <= 1'b0;
  endtask

  task automatic end_test(input logic [7:0] n_addr, input logic [7:0] n_data);
    @(posedge dt_fsm_clk);
    exp_addr_pulses <= n_addr;
    exp_data_pulses <= n_data;
    end_chk         <= 1'b1;
    @(posedge dt_fsm_clk);
    end_chk <= 1'b0;
    @(negedge dt_fsm_clk);
    tests_run++;
    if (test_errs == 0)
      $display("test %s: ok", test_name);
    else
    begin
      $display("test %s: %0d errors", test_name, test_errs);
      tests_failed++;
    end
  endtask

  task automatic set_triggers(input logic addr_en, input logic data_en);
    @(posedge dt_fsm_clk);
    dtu_lsu_addr_trig_en <= addr_en;
    dtu_lsu_data_trig_en <= data_en;
    exp_trig_en          <= addr_en || data_en;
  endtask

  // load or atomic address check up to its request pulse
  task automatic request_addr(input logic amo, input logic split);
    logic [pa_width-1:0]        addr;
    logic [bytes_vld_width-1:0] bytes;
    ldst_type_t                 typ;
    addr  = pa_width'({$urandom, $urandom});
    bytes = bytes_vld_width'($urandom);
    typ   = amo ? ldst_amo : ldst_load;
    @(posedge dt_fsm_clk);
    ag_dtu_req             <= 1'b1;
    ag_dtu_addr_ready      <= 1'b1;
    ag_dtu_st_type         <= 1'b0;
    ag_dtu_amo_type        <= amo;
    ag_dtu_split_last      <= split;
    ag_dtu_addr            <= addr;
    ag_dtu_bytes_vld       <= bytes;
    ag_dtu_halt_info       <= hinfo_width'($urandom);
    ag_dtu_mem_access_size <= size_width'($urandom);
    exp_addr_word          <= {addr, bytes, typ, split && !dtu_lsu_data_trig_en};
    stall_exp              <= 1'b1;
    wait_for(see_addr_req, "the address request");
  endtask

  // trigger unit answer after a random latency, then drain the pipe
  task automatic answer_check(input logic cancel, input int pipe_wait);
    logic [hinfo_width-1:0] hinfo;
    hinfo = hinfo_width'($urandom);
    hinfo[hinfo_cancel_bit] = cancel;
    repeat ($urandom % 4) @(posedge dt_fsm_clk);
    @(posedge dt_fsm_clk);
    dtu_lsu_halt_info_vld <= 1'b1;
    dtu_lsu_halt_info     <= hinfo;
    exp_hinfo             <= hinfo;
    stall_exp             <= 1'b0;
    @(posedge dt_fsm_clk);
    dtu_lsu_halt_info_vld <= 1'b0;
    ag_dtu_req            <= 1'b0;
    repeat (pipe_wait) @(posedge dt_fsm_clk);
    ag_dtu_pipe_down <= 1'b1;
    wait_for(see_idle, "the return to idle");
    @(posedge dt_fsm_clk);
    ag_dtu_pipe_down <= 1'b0;
  endtask

  task automatic data_store;
    logic [data_width-1:0] data;
    logic                  split;
    data  = {$urandom, $urandom};
    split = 1'($urandom);
    @(posedge dt_fsm_clk);
    ag_dtu_req        <= 1'b1;
    ag_dtu_st_type    <= 1'b1;
    ag_dtu_amo_type   <= 1'b0;
    ag_dtu_split_last <= split;
    stall_exp         <= 1'b1;
    @(posedge dt_fsm_clk);
    ag_dtu_data_vld <= 1'b1;
    ag_dtu_data     <= data;
    exp_data_word   <= {data, ldst_store, !dtu_lsu_addr_trig_en || split};
    @(posedge dt_fsm_clk);
    ag_dtu_data_vld <= 1'b0;
    wait_for(see_data_req, "the store data request");
    answer_check(1'b0, 0);
  endtask

  // da wins over ag data offered in the same cycle
  task automatic data_load;
    logic [data_width-1:0] data;
    data = {$urandom, $urandom};
    @(posedge dt_fsm_clk);
    ag_dtu_req        <= 1'b1;
    ag_dtu_st_type    <= 1'b0;
    ag_dtu_amo_type   <= 1'b0;
    ag_dtu_split_last <= 1'b1;
    @(posedge dt_fsm_clk);
    ag_dtu_pipe_down <= 1'b1;
    @(posedge dt_fsm_clk);
    ag_dtu_pipe_down <= 1'b0;
    da_dtu_data_vld  <= 1'b1;
    da_dtu_data      <= data;
    ag_dtu_data_vld  <= 1'b1;
    ag_dtu_data      <= ~data;
    exp_data_word    <= {data, ldst_load, 1'b1};
    stall_exp        <= 1'b1;
    @(posedge dt_fsm_clk);
    da_dtu_data_vld <= 1'b0;
    ag_dtu_data_vld <= 1'b0;
    wait_for(see_data_req, "the load data request");
    answer_check(1'b0, 1);
  endtask

  // ==============================
  // test sequence
  // ==============================
  initial
  begin
    void'($urandom(93052));
    test_name    = "reset";
    test_errs    = 0;
    err_total    = 0;
    tests_run    = 0;
    tests_failed = 0;
    ag_dtu_req             <= 1'b0;
    ag_dtu_addr_ready      <= 1'b0;
    ag_dtu_st_type         <= 1'b0;
    ag_dtu_amo_type        <= 1'b0;
    ag_dtu_split_last      <= 1'b0;
    ag_dtu_data_chk_mask   <= 1'b0;
    ag_dtu_pipe_down       <= 1'b0;
    ag_dtu_addr            <= '0;
    ag_dtu_bytes_vld       <= '0;
    ag_dtu_data            <= '0;
    ag_dtu_data_vld        <= 1'b0;
    ag_dtu_halt_info       <= hinfo_width'($urandom);
    ag_dtu_mem_access_size <= size_width'($urandom);
    da_dtu_data            <= '0;
    da_dtu_data_vld        <= 1'b0;
    vlsu_dtu_data          <= {$urandom, $urandom};
    vlsu_dtu_data_vld      <= 1'b0;
    dtu_lsu_addr_trig_en   <= 1'b0;
    dtu_lsu_data_trig_en   <= 1'b0;
    dtu_lsu_halt_info      <= '0;
    dtu_lsu_halt_info_vld  <= 1'b0;
    rtu_yy_xx_flush        <= 1'b0;
    exp_addr_word          <= '0;
    exp_data_word          <= '0;
    exp_hinfo              <= '0;
    exp_addr_pulses        <= 8'd0;
    exp_data_pulses        <= 8'd0;
    exp_trig_en            <= 1'b0;
    stall_exp              <= 1'b0;
    reset_chk              <= 1'b0;
    end_chk                <= 1'b0;
    cnt_clr                <= 1'b1;
    wait_for(see_reset, "reset release");

    start_test("reset");
    @(posedge dt_fsm_clk);
    reset_chk <= 1'b1;
    @(posedge dt_fsm_clk);
    reset_chk <= 1'b0;
    end_test(8'd0, 8'd0);

    start_test("addr_check");
    set_triggers(1'b1, 1'b0);
    request_addr(1'b0, 1'($urandom));
    answer_check(1'b0, 0);
    request_addr(1'b1, 1'($urandom));
    answer_check(1'b0, 2);
    end_test(8'd2, 8'd0);

    start_test("data_check");
    set_triggers(1'b0, 1'b1);
    data_store();
    data_load();
    end_test(8'd0, 8'd2);

    start_test("cancel");
    set_triggers(1'b1, 1'b0);
    request_addr(1'b0, 1'b0);
    answer_check(1'b1, 3);
    end_test(8'd1, 8'd0);

    start_test("flush");
    request_addr(1'b0, 1'($urandom));
    @(posedge dt_fsm_clk);
    rtu_yy_xx_flush <= 1'b1;
    ag_dtu_req      <= 1'b0;
    stall_exp       <= 1'b0;
    @(posedge dt_fsm_clk);
    rtu_yy_xx_flush <= 1'b0;
    wait_for(see_idle, "idle after the flush");
    end_test(8'd1, 8'd0);

    $display("%0d tests run, %0d passed, %0d failed, %0d errors", tests_run,
             tests_run - tests_failed, tests_failed, err_total);
    if (tests_failed == 0 && err_total == 0)
      $display("TEST PASSED");
    else
      $display("TEST FAILED");
    $finish;
  end

endmodule
